// File: hdl/dram_rx_config.svh
`ifndef DRAM_RX_CONFIG_SVH
`define DRAM_RX_CONFIG_SVH

// Cache side
`define DRX_NUM_CACHE 4
`define DRX_DATA_WIDTH 32
`define DRX_DMA_DATA_WIDTH 32
`define DRX_BLOCK_WORDS 8

// DRAM channel side
`define DRX_DRAM_DATA_WIDTH 64
`define DRX_CH_ADDR_WIDTH 16
`define DRX_FIFO_DEPTH 8 // power of two, pointers wrap naturally

`define DRX_BEATS_PER_BLOCK (`DRX_BLOCK_WORDS*`DRX_DATA_WIDTH/`DRX_DRAM_DATA_WIDTH)
`define DRX_DMA_PER_BLOCK (`DRX_BLOCK_WORDS*`DRX_DATA_WIDTH/`DRX_DMA_DATA_WIDTH)
`define DRX_LG_NUM_CACHE $clog2(`DRX_NUM_CACHE)

`endif

// File: hdl/dram_rx_pkg.sv
`include "dram_rx_config.svh"

package dram_rx_pkg;

  // Channel byte address, top bits pick the cache
  typedef logic [`DRX_CH_ADDR_WIDTH-1:0] ch_addr_t;

  typedef logic [`DRX_DRAM_DATA_WIDTH-1:0] dram_beat_t;

  typedef logic [`DRX_DMA_DATA_WIDTH-1:0] dma_word_t;

  typedef logic [`DRX_LG_NUM_CACHE-1:0] cache_id_t;

  // Drain side of a reorder block
  typedef enum logic {
    e_drain_idle, // drain buffer empty
    e_drain_busy  // words going out
  } drain_state_e;

endpackage

// File: hdl/dram_rx_dispatch.sv
`timescale 1ns/10ps
`include "dram_rx_config.svh"

module dram_rx_dispatch (
  input core_clk_i,
  input reset_i,
  input dram_data_v_i,
  input dram_rx_pkg::dram_beat_t dram_data_i,
  input dram_rx_pkg::ch_addr_t dram_ch_addr_i,
  input [`DRX_NUM_CACHE-1:0] fill_ready_i,
  output dram_rx_pkg::dram_beat_t rx_beat_o,
  output dram_rx_pkg::ch_addr_t rx_ch_addr_o,
  output logic [`DRX_NUM_CACHE-1:0] rx_v_o,
  output logic fifo_full_o
);

  localparam int lg_depth_lp = $clog2(`DRX_FIFO_DEPTH);

  // Address and beat storage, no reset needed on payload
  dram_rx_pkg::dram_beat_t beat_mem [`DRX_FIFO_DEPTH];
  dram_rx_pkg::ch_addr_t addr_mem [`DRX_FIFO_DEPTH];

  logic [lg_depth_lp-1:0] wr_ptr;
  logic [lg_depth_lp-1:0] rd_ptr;
  logic [lg_depth_lp:0] count;
  logic head_v;
  logic fifo_wr;
  logic fifo_rd;
  dram_rx_pkg::cache_id_t head_id;

  assign head_v = (count != '0);
  assign fifo_full_o = (count == (lg_depth_lp+1)'(`DRX_FIFO_DEPTH));

  // A pop on the same edge frees the slot being written
  assign fifo_wr = dram_data_v_i & (~fifo_full_o | fifo_rd);

  assign rx_beat_o = beat_mem[rd_ptr];
  assign rx_ch_addr_o = addr_mem[rd_ptr];

  assign head_id = rx_ch_addr_o[`DRX_CH_ADDR_WIDTH-1 -: `DRX_LG_NUM_CACHE];

  // Decode head beat to its cache, only offered when that cache can take it
  always_comb begin
    rx_v_o = '0;
    rx_v_o[head_id] = head_v;
    rx_v_o = rx_v_o & fill_ready_i;
  end

  assign fifo_rd = |rx_v_o;

  always_ff @(posedge core_clk_i) begin
    if (fifo_wr) begin
      beat_mem[wr_ptr] <= dram_data_i;
      addr_mem[wr_ptr] <= dram_ch_addr_i;
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (reset_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (fifo_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (fifo_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({fifo_wr, fifo_rd})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count; // idle or push and pop together
      endcase
    end
  end

endmodule

// File: hdl/dram_rx_reorder.sv
`timescale 1ns/10ps
`include "dram_rx_config.svh"

module dram_rx_reorder (
  input core_clk_i,
  input reset_i,
  input rx_v_i,
  input dram_rx_pkg::dram_beat_t rx_beat_i,
  input dram_rx_pkg::ch_addr_t rx_ch_addr_i,
  output logic fill_ready_o,
  output dram_rx_pkg::dma_word_t dma_data_o,
  output logic dma_data_v_o,
  input dma_data_ready_i
);

  localparam int beats_lp = `DRX_BEATS_PER_BLOCK;
  localparam int words_lp = `DRX_DMA_PER_BLOCK;
  localparam int lg_beats_lp = $clog2(beats_lp);
  localparam int lg_words_lp = $clog2(words_lp);
  localparam int words_per_beat_lp = `DRX_DRAM_DATA_WIDTH / `DRX_DMA_DATA_WIDTH;
  localparam int beat_offset_lp = $clog2(`DRX_DRAM_DATA_WIDTH / 8); // byte bits in a beat

  // Fill side collects beats in any order
  dram_rx_pkg::dram_beat_t fill_buf [beats_lp];
  logic [beats_lp-1:0] fill_mask;

  // Drain side holds the block as DMA words in address order
  dram_rx_pkg::dma_word_t drain_buf [words_lp];
  dram_rx_pkg::drain_state_e drain_state;
  logic [lg_words_lp-1:0] word_cnt;

  logic [lg_beats_lp-1:0] beat_idx;
  logic fill_full;
  logic fill_wr;
  logic move_block;
  logic word_done;

  assign beat_idx = rx_ch_addr_i[beat_offset_lp +: lg_beats_lp];
  assign fill_full = &fill_mask;
  assign fill_ready_o = ~fill_full;
  assign fill_wr = rx_v_i & fill_ready_o;

  // Full block waits here until the drain buffer is free
  assign move_block = fill_full & (drain_state == dram_rx_pkg::e_drain_idle);

  assign dma_data_v_o = (drain_state == dram_rx_pkg::e_drain_busy);
  assign dma_data_o = drain_buf[word_cnt];
  assign word_done = dma_data_v_o & dma_data_ready_i;

  always_ff @(posedge core_clk_i) begin
    if (fill_wr) begin
      fill_buf[beat_idx] <= rx_beat_i;
    end
    if (move_block) begin
      // Lower address word of each beat is the low half
      for (int b = 0; b < beats_lp; b++) begin
        for (int h = 0; h < words_per_beat_lp; h++) begin
          drain_buf[b*words_per_beat_lp + h] <=
            fill_buf[b][h*`DRX_DMA_DATA_WIDTH +: `DRX_DMA_DATA_WIDTH];
        end
      end
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (reset_i) begin
      fill_mask <= '0;
    end else if (move_block) begin
      fill_mask <= '0;
    end else if (fill_wr) begin
      fill_mask[beat_idx] <= 1'b1;
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (reset_i) begin
      drain_state <= dram_rx_pkg::e_drain_idle;
      word_cnt <= '0;
    end else begin
      case (drain_state)
        dram_rx_pkg::e_drain_idle: begin
          if (move_block) begin
            drain_state <= dram_rx_pkg::e_drain_busy;
            word_cnt <= '0;
          end
        end
        dram_rx_pkg::e_drain_busy: begin
          if (word_done) begin
            word_cnt <= word_cnt + 1'b1;
            if (word_cnt == lg_words_lp'(words_lp - 1)) begin
              drain_state <= dram_rx_pkg::e_drain_idle; // last word taken
            end
          end
        end
        default: drain_state <= dram_rx_pkg::e_drain_idle;
      endcase
    end
  end

endmodule

// File: hdl/dram_rx_top.sv
`timescale 1ns/10ps
`include "dram_rx_config.svh"

module dram_rx_top (
  input core_clk_i,
  input reset_i,
  input dram_data_v_i,
  input dram_rx_pkg::dram_beat_t dram_data_i,
  input dram_rx_pkg::ch_addr_t dram_ch_addr_i,
  output dram_rx_pkg::dma_word_t [`DRX_NUM_CACHE-1:0] dma_data_o,
  output logic [`DRX_NUM_CACHE-1:0] dma_data_v_o,
  input [`DRX_NUM_CACHE-1:0] dma_data_ready_i
);

  // Head of the return FIFO, shared by all reorder blocks
  dram_rx_pkg::dram_beat_t rx_beat;
  dram_rx_pkg::ch_addr_t rx_ch_addr;
  logic [`DRX_NUM_CACHE-1:0] rx_v;       // one-hot
  logic [`DRX_NUM_CACHE-1:0] fill_ready;

  dram_rx_dispatch u_dispatch (
    .core_clk_i(core_clk_i),
    .reset_i(reset_i),
    .dram_data_v_i(dram_data_v_i),
    .dram_data_i(dram_data_i),
    .dram_ch_addr_i(dram_ch_addr_i),
    .fill_ready_i(fill_ready),
    .rx_beat_o(rx_beat),
    .rx_ch_addr_o(rx_ch_addr),
    .rx_v_o(rx_v),
    .fifo_full_o()
  );

  for (genvar i = 0; i < `DRX_NUM_CACHE; i++) begin : g_cache
    dram_rx_reorder u_reorder (
      .core_clk_i(core_clk_i),
      .reset_i(reset_i),
      .rx_v_i(rx_v[i]),
      .rx_beat_i(rx_beat),
      .rx_ch_addr_i(rx_ch_addr),
      .fill_ready_o(fill_ready[i]),
      .dma_data_o(dma_data_o[i]),
      .dma_data_v_o(dma_data_v_o[i]),
      .dma_data_ready_i(dma_data_ready_i[i])
    );
  end

endmodule

// File: bench/dram_rx_clkgen.sv
`timescale 1ns/10ps

module dram_rx_clkgen #(
  parameter int period_p = 40,
  parameter int reset_cycles_p = 5
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #(period_p / 2) clk_o = ~clk_o;
  end

  // Release on a falling edge, clear of the sampling edge
  initial begin
    reset_o = 1'b1;
    repeat (reset_cycles_p) @(posedge clk_o);
    @(negedge clk_o);
    reset_o = 1'b0;
  end

endmodule

// File: bench/dram_rx_assert.sv
`timescale 1ns/10ps
`include "dram_rx_config.svh"

module dram_rx_assert (
  input core_clk_i,
  input reset_i,
  input push_i,
  input full_i,
  input pop_i,
  input [`DRX_NUM_CACHE-1:0] rx_v_i,
  input dma_v_i,
  input dma_ready_i,
  input dram_rx_pkg::dma_word_t dma_data_i
);

  // The DRAM side has no ready, a push into a full FIFO loses a beat
  no_overrun: assert property (@(posedge core_clk_i) disable iff (reset_i)
    !(push_i && full_i && !pop_i))
    else $error("return FIFO written while full");

  dma_hold: assert property (@(posedge core_clk_i) disable iff (reset_i)
    (dma_v_i && !dma_ready_i) |=> (dma_v_i && $stable(dma_data_i)))
    else $error("DMA word changed or dropped while the cache stalled");

  rx_v_onehot: assert property (@(posedge core_clk_i) disable iff (reset_i)
    $onehot0(rx_v_i))
    else $error("FIFO head offered to more than one reorder block");

endmodule

bind dram_rx_dispatch dram_rx_assert u_fifo_check (
  .core_clk_i(core_clk_i),
  .reset_i(reset_i),
  .push_i(dram_data_v_i),
  .full_i(fifo_full_o),
  .pop_i(fifo_rd),
  .rx_v_i(rx_v_o),
  .dma_v_i(1'b0),
  .dma_ready_i(1'b0),
  .dma_data_i('0)
);

// Only the DMA side applies here
bind dram_rx_reorder dram_rx_assert u_dma_check (
  .core_clk_i(core_clk_i),
  .reset_i(reset_i),
  .push_i(1'b0),
  .full_i(1'b0),
  .pop_i(1'b0),
  .rx_v_i('0),
  .dma_v_i(dma_data_v_o),
  .dma_ready_i(dma_data_ready_i),
  .dma_data_i(dma_data_o)
);

// File: bench/dram_rx_tb.sv
`timescale 1ns/10ps
`include "dram_rx_config.svh"

module dram_rx_tb;

  localparam int tbl_len_lp = 12;
  localparam int num_groups_lp = 5;
  localparam int words_per_beat_lp = `DRX_DRAM_DATA_WIDTH / `DRX_DMA_DATA_WIDTH;
  localparam int hold_cycles_lp = 30;

  // Block table with group 0 as the check after reset
  localparam int tbl_cache [tbl_len_lp] = '{0, 1, 2, 3, 0, 1, 3, 0, 2, 2, 2, 1};
  localparam dram_rx_pkg::ch_addr_t tbl_addr [tbl_len_lp] = '{
    16'h0000, 16'h4020, 16'h8040, 16'hc060, 16'h0100, 16'h4200,
    16'hc220, 16'h0240, 16'h8260, 16'h8300, 16'h8320, 16'h4340
  };
  // Beat sent at step k sits in bits 2k+1:2k
  localparam logic [7:0] tbl_perm [tbl_len_lp] = '{
    8'he4, 8'he4, 8'h1b, 8'h72, 8'h8d, 8'h27, 8'hd8, 8'he4, 8'h1b, 8'h72, 8'h8d, 8'h27
  };
  localparam bit tbl_bp [tbl_len_lp] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 1};
  localparam int tbl_grp [tbl_len_lp] = '{1, 1, 2, 2, 2, 3, 3, 3, 3, 4, 4, 4};

  logic core_clk;
  logic reset;
  logic dram_data_v = 1'b0;
  dram_rx_pkg::dram_beat_t dram_data = '0;
  dram_rx_pkg::ch_addr_t dram_ch_addr = '0;
  dram_rx_pkg::dma_word_t [`DRX_NUM_CACHE-1:0] dma_data;
  logic [`DRX_NUM_CACHE-1:0] dma_data_v;
  logic [`DRX_NUM_CACHE-1:0] dma_ready = '1;

  dram_rx_pkg::dram_beat_t beat_data [tbl_len_lp][`DRX_BEATS_PER_BLOCK];
  dram_rx_pkg::dma_word_t exp_q [`DRX_NUM_CACHE][$]; // Per cache in issue order
  int exp_grp [`DRX_NUM_CACHE][$];
  int grp_total [num_groups_lp];
  int grp_done [num_groups_lp];
  int grp_checks [num_groups_lp];
  int grp_err [num_groups_lp];
  int bp_req [`DRX_NUM_CACHE];
  int bp_seen [`DRX_NUM_CACHE];
  int hold_cnt [`DRX_NUM_CACHE];
  bit [`DRX_NUM_CACHE-1:0] bp_mode;
  int beats_sent;
  int words_taken;
  int checks;
  int errors;
  bit first_done;
  bit reset_reported;

  dram_rx_clkgen u_clkgen (.clk_o(core_clk), .reset_o(reset));

  dram_rx_top u_dram_rx_top (
    .core_clk_i(core_clk),
    .reset_i(reset),
    .dram_data_v_i(dram_data_v),
    .dram_data_i(dram_data),
    .dram_ch_addr_i(dram_ch_addr),
    .dma_data_o(dma_data),
    .dma_data_v_o(dma_data_v),
    .dma_data_ready_i(dma_ready)
  );

  function automatic string group_name(input int g);
    case (g)
      0: return "reset";
      1: return "in_order";
      2: return "shuffled";
      3: return "interleave";
      default: return "backpressure";
    endcase
  endfunction

  task automatic report_group(input int g);
    $display("%s: %0d checks, %0d errors", group_name(g), grp_checks[g], grp_err[g]);
  endtask

  // Held low for a while after a stalled block is issued and random after that
  task automatic update_ready(input int c);
    if (bp_req[c] != bp_seen[c]) begin
      bp_seen[c] = bp_req[c];
      bp_mode[c] = 1'b1;
      hold_cnt[c] = hold_cycles_lp;
    end
    if (hold_cnt[c] > 0) begin
      hold_cnt[c]--;
      dma_ready[c] = 1'b0;
    end else if (bp_mode[c]) begin
      dma_ready[c] = 1'($urandom % 2);
    end else begin
      dma_ready[c] = 1'b1;
    end
  endtask

  task automatic check_word(input int c);
    dram_rx_pkg::dma_word_t exp;
    int g;
    if (!reset_reported) begin
      reset_reported = 1'b1;
      report_group(0);
    end
    assert (exp_q[c].size() != 0) else begin
      $display("ERROR: cache %0d took a word at %0d ns with no block outstanding", c, $time);
      errors++;
    end
    if (exp_q[c].size() != 0) begin
      exp = exp_q[c].pop_front();
      g = exp_grp[c].pop_front();
      checks++;
      grp_checks[g]++;
      assert (dma_data[c] == exp) else begin
        $display("mismatch at %0d ns: cache %0d got %h expected %h", $time, c, dma_data[c], exp);
        errors++;
        grp_err[g]++;
      end
      grp_done[g]++;
      if (grp_done[g] == grp_total[g]) report_group(g);
    end
  endtask

  // Ready changes here, so valid and ready below decide the next rising edge
  always @(negedge core_clk) begin : monitor
    int taken;
    taken = 0;
    if (!first_done && !reset) begin
      checks++;
      grp_checks[0]++;
      assert (dma_data_v == '0) else begin
        $display("ERROR: dma_data_v_o high at %0d ns before any block was complete", $time);
        errors++;
        grp_err[0]++;
      end
    end
    for (int c = 0; c < `DRX_NUM_CACHE; c++) begin
      update_ready(c);
      if (dma_data_v[c] && dma_ready[c]) begin
        taken++;
        check_word(c);
      end
    end
    words_taken <= words_taken + taken;
  end

  task automatic send_beat(input dram_rx_pkg::ch_addr_t addr, input dram_rx_pkg::dram_beat_t data);
    @(negedge core_clk);
    // Beats not yet out as words bound what the FIFO can hold
    while (beats_sent - words_taken / words_per_beat_lp >= `DRX_FIFO_DEPTH) begin
      dram_data_v = 1'b0;
      @(negedge core_clk);
    end
    dram_data_v = 1'b1;
    dram_ch_addr = addr;
    dram_data = data;
    beats_sent++;
  endtask

  task automatic send_block(input int e);
    int c;
    logic [1:0] b;
    c = tbl_cache[e];
    for (int w = 0; w < `DRX_DMA_PER_BLOCK; w++) begin
      exp_q[c].push_back(beat_data[e][w / words_per_beat_lp]
        [(w % words_per_beat_lp) * `DRX_DMA_DATA_WIDTH +: `DRX_DMA_DATA_WIDTH]);
      exp_grp[c].push_back(tbl_grp[e]);
    end
    if (tbl_bp[e]) bp_req[c] <= bp_req[c] + 1;
    for (int k = 0; k < `DRX_BEATS_PER_BLOCK; k++) begin
      b = tbl_perm[e][2*k +: 2];
      send_beat({tbl_addr[e][`DRX_CH_ADDR_WIDTH-1:5], b, 3'b000}, beat_data[e][b]);
    end
    if (e == 0) first_done <= 1'b1;
  endtask

  initial begin : driver
    void'($urandom(32'hd85a_b871));
    for (int e = 0; e < tbl_len_lp; e++) begin
      for (int b = 0; b < `DRX_BEATS_PER_BLOCK; b++) begin
        beat_data[e][b] = {$urandom, $urandom};
      end
      grp_total[tbl_grp[e]] += `DRX_DMA_PER_BLOCK;
    end
    @(negedge reset);
    for (int e = 0; e < tbl_len_lp; e++) begin
      send_block(e);
    end
    @(negedge core_clk);
    dram_data_v = 1'b0;
    wait (words_taken == tbl_len_lp * `DRX_DMA_PER_BLOCK);
    repeat (20) @(negedge core_clk); // catch stray words
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (tbl_len_lp * 40 + 200) @(posedge core_clk);
    $display("ERROR: timeout, not every block came back on the DMA ports in time");
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: flist.f
+incdir+hdl
hdl/dram_rx_pkg.sv
hdl/dram_rx_dispatch.sv
hdl/dram_rx_reorder.sv
hdl/dram_rx_top.sv
bench/dram_rx_clkgen.sv
bench/dram_rx_assert.sv
bench/dram_rx_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the dram_rx testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module dram_rx_tb -o dram_rx_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/dram_rx_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation finished: PASS"; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1
